// File: logic/colorBlender.sv
`timescale 1ns/100ps
`default_nettype none

module colorBlender import rasterPkg::*; (
    input  logic      aclk,
    input  logic      arstN,
    input  colorT     fragColor,
    input  colorT     storedColor,
    input  blendModeT blendMode,
    input  colorMaskT colorMask,
    output colorT     blendedColor
);

    colorT blendNext;

    //////////////////////////////////////////////////
    // Per channel blend, nibble 3 is red
    //////////////////////////////////////////////////
    always_comb begin
        logic [4:0] sum;
        logic [3:0] mixed;

        // Masked channels keep the stored value
        blendNext = storedColor;
        for (int ch = 0; ch < 4; ch++) begin
            sum = {1'b0, fragColor[ch*4 +: 4]} + {1'b0, storedColor[ch*4 +: 4]};
            case (blendMode)
                ADD: begin
                    // Saturate at 15
                    mixed = sum[4] ? 4'hf : sum[3:0];
                end
                AVERAGE: begin
                    mixed = sum[4:1];
                end
                default: begin
                    mixed = fragColor[ch*4 +: 4];
                end
            endcase
            if (colorMask[ch]) begin
                blendNext[ch*4 +: 4] = mixed;
            end
        end
    end

    always_ff @(posedge aclk or negedge arstN) begin
        if (!arstN) begin
            blendedColor <= '0;
        end else begin
            blendedColor <= blendNext;
        end
    end

endmodule

`default_nettype wire

// File: logic/depthTester.sv
`timescale 1ns/100ps
`default_nettype none

module depthTester import rasterPkg::*; (
    input  logic      aclk,
    input  logic      arstN,
    input  depthT     fragDepth,
    input  depthT     storedDepth,
    input  depthFuncT depthFunc,
    output logic      depthPass
);

    logic passNext;

    // Fragment on the left side of every comparison
    always_comb begin
        case (depthFunc)
            NEVER: begin
                passNext = 1'b0;
            end
            LESS: begin
                passNext = fragDepth < storedDepth;
            end
            LEQUAL: begin
                passNext = fragDepth <= storedDepth;
            end
            EQUAL: begin
                passNext = fragDepth == storedDepth;
            end
            GREATER: begin
                passNext = fragDepth > storedDepth;
            end
            NOTEQUAL: begin
                passNext = fragDepth != storedDepth;
            end
            GEQUAL: begin
                passNext = fragDepth >= storedDepth;
            end
            default: begin
                passNext = 1'b1;
            end
        endcase
    end

    // One cycle of latency, same as the blender
    always_ff @(posedge aclk or negedge arstN) begin
        if (!arstN) begin
            depthPass <= 1'b0;
        end else begin
            depthPass <= passNext;
        end
    end

endmodule

`default_nettype wire

// File: logic/fragmentBackend.sv
`timescale 1ns/100ps
`default_nettype none

module fragmentBackend import rasterPkg::*; (
    input  logic       aclk,
    input  logic       arstN,
    input  logic       fragValid,
    output logic       fragReady,
    input  pixelIndexT fragIndex,
    input  depthT      fragDepth,
    input  colorT      fragColor,
    input  depthFuncT  depthFunc,
    input  logic       depthWriteEn,
    input  blendModeT  blendMode,
    input  colorMaskT  colorMask,
    input  colorT      clearColor,
    input  depthT      clearDepth,
    input  logic       clearStart,
    input  logic       dumpStart,
    output logic       busy,
    output logic       pixValid,
    input  logic       pixReady,
    output logic       pixLast,
    output colorT      pixData
);

    //////////////////////////////////////////////////
    // Wires
    //////////////////////////////////////////////////
    logic       rdEn;
    pixelIndexT rdIndex;
    colorT      storedColor;
    depthT      storedDepth;
    depthT      stageDepth;
    colorT      stageColor;
    logic       depthPass;
    colorT      blendedColor;
    pixelIndexT wrIndex;
    logic       colorWrEn;
    logic       depthWrEn;
    colorT      colorWrData;
    depthT      depthWrData;
    logic       idle;
    logic       colorBusy;
    logic       depthBusy;
    logic       clearGo;
    logic       dumpGo;

    assign busy = colorBusy || depthBusy;

    // Commands only start on an empty pipeline
    assign clearGo = clearStart && idle;
    assign dumpGo  = dumpStart && idle;

    //////////////////////////////////////////////////
    // Pipeline
    //////////////////////////////////////////////////
    fragmentWriter writer (
        .aclk(aclk),
        .arstN(arstN),
        .fragValid(fragValid),
        .fragReady(fragReady),
        .fragIndex(fragIndex),
        .fragDepth(fragDepth),
        .fragColor(fragColor),
        .busy(busy),
        .clearStart(clearStart),
        .dumpStart(dumpStart),
        .rdEn(rdEn),
        .rdIndex(rdIndex),
        .stageDepth(stageDepth),
        .stageColor(stageColor),
        .depthPass(depthPass),
        .blendedColor(blendedColor),
        .depthWriteEn(depthWriteEn),
        .wrIndex(wrIndex),
        .colorWrEn(colorWrEn),
        .depthWrEn(depthWrEn),
        .colorWrData(colorWrData),
        .depthWrData(depthWrData),
        .idle(idle)
    );

    depthTester depthTest (
        .aclk(aclk),
        .arstN(arstN),
        .fragDepth(stageDepth),
        .storedDepth(storedDepth),
        .depthFunc(depthFunc),
        .depthPass(depthPass)
    );

    colorBlender blender (
        .aclk(aclk),
        .arstN(arstN),
        .fragColor(stageColor),
        .storedColor(storedColor),
        .blendMode(blendMode),
        .colorMask(colorMask),
        .blendedColor(blendedColor)
    );

    //////////////////////////////////////////////////
    // Buffers
    //////////////////////////////////////////////////
    frameBuffer #(
        .PIXEL_WIDTH($bits(colorT))
    ) colorBuffer (
        .aclk(aclk),
        .arstN(arstN),
        .rdEn(rdEn),
        .rdIndex(rdIndex),
        .rdData(storedColor),
        .wrEn(colorWrEn),
        .wrIndex(wrIndex),
        .wrData(colorWrData),
        .clearStart(clearGo),
        .clearValue(clearColor),
        .dumpStart(dumpGo),
        .busy(colorBusy),
        .pixValid(pixValid),
        .pixReady(pixReady),
        .pixLast(pixLast),
        .pixData(pixData)
    );

    // Depth is never streamed out
    frameBuffer #(
        .PIXEL_WIDTH($bits(depthT))
    ) depthBuffer (
        .aclk(aclk),
        .arstN(arstN),
        .rdEn(rdEn),
        .rdIndex(rdIndex),
        .rdData(storedDepth),
        .wrEn(depthWrEn),
        .wrIndex(wrIndex),
        .wrData(depthWrData),
        .clearStart(clearGo),
        .clearValue(clearDepth),
        .dumpStart(1'b0),
        .busy(depthBusy),
        .pixValid(),
        .pixReady(1'b1),
        .pixLast(),
        .pixData()
    );

endmodule

`default_nettype wire

// File: logic/fragmentWriter.sv
`timescale 1ns/100ps
`default_nettype none

module fragmentWriter import rasterPkg::*; (
    input  logic       aclk,
    input  logic       arstN,
    input  logic       fragValid,
    output logic       fragReady,
    input  pixelIndexT fragIndex,
    input  depthT      fragDepth,
    input  colorT      fragColor,
    input  logic       busy,
    input  logic       clearStart,
    input  logic       dumpStart,
    output logic       rdEn,
    output pixelIndexT rdIndex,
    output depthT      stageDepth,
    output colorT      stageColor,
    input  logic       depthPass,
    input  colorT      blendedColor,
    input  logic       depthWriteEn,
    output pixelIndexT wrIndex,
    output logic       colorWrEn,
    output logic       depthWrEn,
    output colorT      colorWrData,
    output depthT      depthWrData,
    output logic       idle
);

    // Stage 1, stored values arrive from the buffers
    logic       s1Valid;
    pixelIndexT s1Index;
    depthT      s1Depth;
    colorT      s1Color;
    // Stage 2, unit results ready for the write
    logic       s2Valid;
    pixelIndexT s2Index;
    depthT      s2Depth;
    // Low for the first cycle out of reset
    logic       running;
    logic       hazard;
    logic       accept;

    // Read after pending write to the same pixel
    assign hazard = (s1Valid && s1Index == fragIndex) || (s2Valid && s2Index == fragIndex);

    assign fragReady = running && !busy && !clearStart && !dumpStart && !hazard;
    assign accept    = fragValid && fragReady;

    assign rdEn       = accept;
    assign rdIndex    = fragIndex;
    assign stageDepth = s1Depth;
    assign stageColor = s1Color;

    assign wrIndex     = s2Index;
    assign colorWrEn   = s2Valid && depthPass;
    assign depthWrEn   = s2Valid && depthPass && depthWriteEn;
    assign colorWrData = blendedColor;
    assign depthWrData = s2Depth;
    assign idle        = !s1Valid && !s2Valid;

    always_ff @(posedge aclk or negedge arstN) begin
        if (!arstN) begin
            running <= 1'b0;
            s1Valid <= 1'b0;
            s2Valid <= 1'b0;
        end else begin
            running <= 1'b1;
            s1Valid <= accept;
            s2Valid <= s1Valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            s1Index <= fragIndex;
            s1Depth <= fragDepth;
            s1Color <= fragColor;
        end
        s2Index <= s1Index;
        s2Depth <= s1Depth;
    end

endmodule

`default_nettype wire

// File: logic/frameBuffer.sv
`timescale 1ns/100ps
`default_nettype none

`include "raster_defines.svh"

module frameBuffer import rasterPkg::*; #(
    parameter int PIXEL_WIDTH = 16
) (
    input  logic                   aclk,
    input  logic                   arstN,
    input  logic                   rdEn,
    input  pixelIndexT             rdIndex,
    output logic [PIXEL_WIDTH-1:0] rdData,
    input  logic                   wrEn,
    input  pixelIndexT             wrIndex,
    input  logic [PIXEL_WIDTH-1:0] wrData,
    input  logic                   clearStart,
    input  logic [PIXEL_WIDTH-1:0] clearValue,
    input  logic                   dumpStart,
    output logic                   busy,
    output logic                   pixValid,
    input  logic                   pixReady,
    output logic                   pixLast,
    output logic [PIXEL_WIDTH-1:0] pixData
);

    typedef enum logic [1:0] {IDLE, CLEAR, DUMP} fbStateT;

    logic [PIXEL_WIDTH-1:0] mem [`FB_SIZE];

    fbStateT                state;
    pixelIndexT             sweepAddr;
    logic                   sweepEnd;
    // rdData holds a dump word not yet moved to the output register
    logic                   fetchValid;
    // Last dump read issued, so the fetched word is the final pixel
    logic                   fetchLast;
    logic                   outLoad;
    logic                   dumpRead;
    logic                   ramWrEn;
    pixelIndexT             ramWrAddr;
    logic [PIXEL_WIDTH-1:0] ramWrData;
    logic                   ramRdEn;
    pixelIndexT             ramRdAddr;

    assign sweepEnd = sweepAddr == pixelIndexT'(`FB_SIZE - 1);
    assign busy     = state != IDLE;

    // Dump prefetch, refill rdData as soon as its word moves on
    assign outLoad  = fetchValid && (!pixValid || pixReady);
    assign dumpRead = (state == DUMP) && !fetchLast && (!fetchValid || outLoad);

    // Clear owns the write port, dump owns the read port
    assign ramWrEn   = (state == CLEAR) || wrEn;
    assign ramWrAddr = (state == CLEAR) ? sweepAddr : wrIndex;
    assign ramWrData = (state == CLEAR) ? clearValue : wrData;
    assign ramRdEn   = (state == DUMP) ? dumpRead : rdEn;
    assign ramRdAddr = (state == DUMP) ? sweepAddr : rdIndex;

    //////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (ramWrEn) begin
            mem[ramWrAddr] <= ramWrData;
        end
        if (ramRdEn) begin
            rdData <= mem[ramRdAddr];
        end
        if (outLoad) begin
            pixData <= rdData;
        end
    end

    //////////////////////////////////////////////////
    // Sweep control and stream output
    //////////////////////////////////////////////////
    always_ff @(posedge aclk or negedge arstN) begin
        if (!arstN) begin
            state      <= IDLE;
            sweepAddr  <= '0;
            fetchValid <= 1'b0;
            fetchLast  <= 1'b0;
            pixValid   <= 1'b0;
            pixLast    <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    sweepAddr <= '0;
                    fetchLast <= 1'b0;
                    if (clearStart) begin
                        state <= CLEAR;
                    end else if (dumpStart) begin
                        state <= DUMP;
                    end
                end
                CLEAR: begin
                    // One word per cycle, FB_SIZE cycles in total
                    sweepAddr <= sweepAddr + 1'b1;
                    if (sweepEnd) begin
                        state <= IDLE;
                    end
                end
                DUMP: begin
                    if (dumpRead) begin
                        sweepAddr <= sweepAddr + 1'b1;
                        fetchLast <= sweepEnd;
                    end
                    if (pixValid && pixReady && pixLast) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase

            if (dumpRead) begin
                fetchValid <= 1'b1;
            end else if (outLoad) begin
                fetchValid <= 1'b0;
            end

            // Output word holds until taken
            if (outLoad) begin
                pixValid <= 1'b1;
                pixLast  <= fetchLast;
            end else if (pixReady) begin
                pixValid <= 1'b0;
                pixLast  <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/rasterPkg.sv
`default_nettype none

`include "raster_defines.svh"

package rasterPkg;

    typedef logic [`FB_INDEX_WIDTH-1:0] pixelIndexT;

    // Red in the top nibble, alpha in the bottom nibble
    typedef logic [`COLOR_WIDTH-1:0] colorT;

    typedef logic [`DEPTH_WIDTH-1:0] depthT;

    // Write enables, bit 3 is red down to bit 0 for alpha
    typedef logic [3:0] colorMaskT;

    // Fragment depth compared against stored depth
    typedef enum logic [2:0] {
        NEVER    = 3'd0,
        LESS     = 3'd1,
        LEQUAL   = 3'd2,
        EQUAL    = 3'd3,
        GREATER  = 3'd4,
        NOTEQUAL = 3'd5,
        GEQUAL   = 3'd6,
        ALWAYS   = 3'd7
    } depthFuncT;

    typedef enum logic [1:0] {
        REPLACE = 2'd0,
        ADD     = 2'd1,
        AVERAGE = 2'd2
    } blendModeT;

endpackage

`default_nettype wire

// File: logic/raster_defines.svh
`ifndef RASTER_DEFINES_SVH
`define RASTER_DEFINES_SVH

// Screen size in pixels
`define FB_X_RES 16
`define FB_Y_RES 8

// Pixel count of one frame buffer
`define FB_SIZE (`FB_X_RES * `FB_Y_RES)

// Bits of a linear, row-major pixel index
`define FB_INDEX_WIDTH 7

// RGBA4444
`define COLOR_WIDTH 16

// Unsigned, smaller is nearer
`define DEPTH_WIDTH 16

`endif

// File: testbench/fragmentBackendTb.sv
`timescale 1ns/100ps
`default_nettype none

`include "raster_defines.svh"

module fragmentBackendTb import rasterPkg::*; ();

    localparam int TIMEOUT_CYCLES = 20000;

    logic       aclk;
    logic       arstN;
    logic       fragValid;
    logic       fragReady;
    pixelIndexT fragIndex;
    depthT      fragDepth;
    colorT      fragColor;
    depthFuncT  depthFunc;
    logic       depthWriteEn;
    blendModeT  blendMode;
    colorMaskT  colorMask;
    colorT      clearColor;
    depthT      clearDepth;
    logic       clearStart;
    logic       dumpStart;
    logic       busy;
    logic       pixValid;
    logic       pixReady;
    logic       pixLast;
    colorT      pixData;

    // Reference copies of both buffers
    colorT colorModel [`FB_SIZE];
    depthT depthModel [`FB_SIZE];
    int    errors;
    int    checks;
    int    cycleCount;

    fragmentBackend dut (.*);

    initial begin
        aclk = 1'b0;
    end

    always #2 aclk = ~aclk;

    always @(posedge aclk) begin
        cycleCount++;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycleCount);
            $display("=== FAIL ===");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Reference rules
    //////////////////////////////////////////////////
    function automatic logic depthPassRef(depthFuncT func, depthT frag, depthT stored);
        logic less;
        logic equal;

        less  = frag < stored;
        equal = frag == stored;
        case (func)
            NEVER:    return 1'b0;
            LESS:     return less;
            LEQUAL:   return less || equal;
            EQUAL:    return equal;
            GREATER:  return !less && !equal;
            NOTEQUAL: return !equal;
            GEQUAL:   return !less;
            default:  return 1'b1;
        endcase
    endfunction

    function automatic colorT blendRef(blendModeT mode, colorMaskT mask, colorT frag,
                                       colorT stored);
        colorT result;
        int    f;
        int    s;
        int    mixed;

        result = stored;
        for (int c = 0; c < 4; c++) begin
            f = (frag >> (4 * c)) & 15;
            s = (stored >> (4 * c)) & 15;
            if (mode == ADD) begin
                mixed = (f + s > 15) ? 15 : f + s;
            end else if (mode == AVERAGE) begin
                mixed = (f + s) / 2;
            end else begin
                mixed = f;
            end
            if (mask[c]) begin
                result[4*c +: 4] = mixed[3:0];
            end
        end
        return result;
    endfunction

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////
    task automatic checkColor(string testName, colorT expected, colorT actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %s color expected %h actual %h", testName, expected, actual);
        end
    endtask

    task automatic checkDepth(string testName, depthT expected, depthT actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %s depth expected %h actual %h", testName, expected, actual);
        end
    endtask

    task automatic checkBit(string testName, logic expected, logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %s flag expected %b actual %b", testName, expected, actual);
        end
    endtask

    //////////////////////////////////////////////////
    // Drivers
    //////////////////////////////////////////////////
    task automatic step();
        @(posedge aclk);
        #0.5;
    endtask

    task automatic setConfig(depthFuncT func, logic wrDepth, blendModeT mode, colorMaskT mask);
        depthFunc    = func;
        depthWriteEn = wrDepth;
        blendMode    = mode;
        colorMask    = mask;
    endtask

    // Held until taken, then applied to the model in arrival order
    task automatic sendFrag(pixelIndexT idx, depthT depth, colorT color);
        logic taken;

        fragValid = 1'b1;
        fragIndex = idx;
        fragDepth = depth;
        fragColor = color;
        taken     = 1'b0;
        while (!taken) begin
            @(negedge aclk);
            taken = fragReady;
            step();
        end
        if (depthPassRef(depthFunc, depth, depthModel[idx])) begin
            colorModel[idx] = blendRef(blendMode, colorMask, color, colorModel[idx]);
            if (depthWriteEn) begin
                depthModel[idx] = depth;
            end
        end
    endtask

    // Last write lands two edges after acceptance
    task automatic drain();
        fragValid = 1'b0;
        step();
        step();
    endtask

    task automatic runClear(string testName, colorT cColor, depthT cDepth);
        int count;

        clearColor = cColor;
        clearDepth = cDepth;
        clearStart = 1'b1;
        step();
        clearStart = 1'b0;
        count = 0;
        while (busy) begin
            count++;
            step();
        end
        checks++;
        if (count != `FB_SIZE) begin
            errors++;
            $display("ERR %s busy cycles expected %0d actual %0d", testName, `FB_SIZE,
                     count);
        end
        for (int i = 0; i < `FB_SIZE; i++) begin
            colorModel[i] = cColor;
            depthModel[i] = cDepth;
        end
    endtask

    task automatic runDump(string testName, logic randomReady);
        int   n;
        logic done;

        dumpStart = 1'b1;
        step();
        dumpStart = 1'b0;
        n    = 0;
        done = 1'b0;
        while (!done) begin
            pixReady = randomReady ? logic'($urandom & 1) : 1'b1;
            if (pixValid && pixReady) begin
                checkColor(testName, colorModel[n], pixData);
                checkBit(testName, n == `FB_SIZE - 1, pixLast);
                done = pixLast || (n == `FB_SIZE - 1);
                n++;
            end
            step();
        end
        pixReady = 1'b1;
        while (busy) begin
            step();
        end
        // Depth buffer against the model
        for (int i = 0; i < `FB_SIZE; i++) begin
            checkDepth(testName, depthModel[i], dut.depthBuffer.mem[i]);
        end
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////
    task automatic testClear();
        runClear("clear", colorT'($urandom), depthT'($urandom));
        runDump("clear", 1'b0);
    endtask

    task automatic testDepthFuncs();
        runClear("depthFunc", colorT'($urandom), 16'h8000);
        for (int f = 0; f < 8; f++) begin
            setConfig(depthFuncT'(f), 1'b1, REPLACE, 4'hf);
            sendFrag(pixelIndexT'(f * 3), depthT'($urandom), colorT'($urandom));
            sendFrag(pixelIndexT'(f * 3 + 1), 16'h8000, colorT'($urandom));
            sendFrag(pixelIndexT'(f * 3 + 2), ($urandom & 1) ? 16'h7fff : 16'h8001,
                     colorT'($urandom));
            drain();
        end
        runDump("depthFunc", 1'b0);
    endtask

    task automatic testDepthWrite();
        runClear("depthWrite", 16'h0000, 16'h8000);
        // Far fragment still passes against the untouched depth
        setConfig(LESS, 1'b0, REPLACE, 4'hf);
        sendFrag(7'd5, 16'h1000, 16'h1111);
        sendFrag(7'd5, 16'h4000, 16'h2222);
        drain();
        setConfig(LESS, 1'b1, REPLACE, 4'hf);
        sendFrag(7'd6, 16'h1000, 16'h3333);
        sendFrag(7'd6, 16'h4000, 16'h4444);
        drain();
        checkColor("depthWrite", 16'h2222, dut.colorBuffer.mem[5]);
        checkColor("depthWrite", 16'h3333, dut.colorBuffer.mem[6]);
        checkDepth("depthWrite", 16'h8000, dut.depthBuffer.mem[5]);
        checkDepth("depthWrite", 16'h1000, dut.depthBuffer.mem[6]);
        runDump("depthWrite", 1'b0);
    endtask

    task automatic testBlend();
        blendModeT modes [3];

        modes = '{ADD, AVERAGE, REPLACE};
        for (int m = 0; m < 3; m++) begin
            setConfig(ALWAYS, logic'($urandom & 1), modes[m], colorMaskT'($urandom));
            repeat (20) begin
                sendFrag(pixelIndexT'($urandom), depthT'($urandom), colorT'($urandom));
            end
            drain();
        end
        runDump("blend", 1'b0);
    endtask

    // Few distinct pixels make most fragments hit one still in flight
    task automatic testHazard();
        setConfig(ALWAYS, 1'b1, ADD, 4'hf);
        repeat (40) begin
            sendFrag(pixelIndexT'(8 + ($urandom % 4)), depthT'($urandom),
                     colorT'($urandom) & 16'h3333);
        end
        drain();
        runDump("hazard", 1'b0);
    endtask

    task automatic testStream();
        runDump("stream", 1'b1);
    endtask

    initial begin
        void'($urandom(32'hc296_5247));
        errors       = 0;
        checks       = 0;
        cycleCount   = 0;
        arstN        = 1'b0;
        fragValid    = 1'b0;
        fragIndex    = '0;
        fragDepth    = '0;
        fragColor    = '0;
        depthFunc    = ALWAYS;
        depthWriteEn = 1'b0;
        blendMode    = REPLACE;
        colorMask    = 4'hf;
        clearColor   = '0;
        clearDepth   = '0;
        clearStart   = 1'b0;
        dumpStart    = 1'b0;
        pixReady     = 1'b1;
        repeat (8) @(posedge aclk);
        #0.5;
        arstN = 1'b1;
        step();

        testClear();
        testDepthFuncs();
        testDepthWrite();
        testBlend();
        testHazard();
        testStream();

        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/fragmentBackend_chk.sv
`timescale 1ns/100ps
`default_nettype none

module fragmentBackendChk import rasterPkg::*; (
    input logic  aclk,
    input logic  arstN,
    input logic  fragReady,
    input logic  busy,
    input logic  pixValid,
    input logic  pixReady,
    input logic  pixLast,
    input colorT pixData,
    input logic  colorWrEn,
    input logic  depthWrEn
);

    // Stream word holds under back-pressure
    property streamHold;
        @(posedge aclk) disable iff (!arstN)
        pixValid && !pixReady |=> pixValid && $stable(pixData) && $stable(pixLast);
    endproperty

    property lastWithValid;
        @(posedge aclk) disable iff (!arstN)
        pixLast |-> pixValid;
    endproperty

    property noAcceptWhileBusy;
        @(posedge aclk) disable iff (!arstN)
        busy |-> !fragReady;
    endproperty

    // Clear and dump own the buffers, so the writer stays quiet
    property noWriteWhileBusy;
        @(posedge aclk) disable iff (!arstN)
        busy |-> !(colorWrEn || depthWrEn);
    endproperty

    streamHoldA: assert property (streamHold)
        else $error("Readout word changed while the stream was stalled");
    lastWithValidA: assert property (lastWithValid)
        else $error("pixLast high without pixValid");
    noAcceptWhileBusyA: assert property (noAcceptWhileBusy)
        else $error("fragReady high while a command runs");
    noWriteWhileBusyA: assert property (noWriteWhileBusy)
        else $error("Write strobe high while a command runs");

endmodule

bind fragmentBackend fragmentBackendChk chk (
    .aclk(aclk),
    .arstN(arstN),
    .fragReady(fragReady),
    .busy(busy),
    .pixValid(pixValid),
    .pixReady(pixReady),
    .pixLast(pixLast),
    .pixData(pixData),
    .colorWrEn(colorWrEn),
    .depthWrEn(depthWrEn)
);

`default_nettype wire

// File: verilog.f
+incdir+logic
logic/rasterPkg.sv
logic/frameBuffer.sv
logic/depthTester.sv
logic/colorBlender.sv
logic/fragmentWriter.sv
logic/fragmentBackend.sv
testbench/fragmentBackend_chk.sv
testbench/fragmentBackendTb.sv
